// File: design/image_pkg.sv
`default_nettype none

package image_pkg;

  // frame geometry
  localparam int IMG_W = 32;
  localparam int IMG_H = 16;

  // pixels carried per stream beat
  localparam int LANES = 4;
  localparam int BEATS_PER_ROW = IMG_W / LANES;

  localparam int PIX_W = 8;

  typedef logic [PIX_W-1:0] pixel_t;

  // pixel 0 sits in the low byte and is leftmost on screen
  typedef logic [LANES*PIX_W-1:0] beat_t;

  // one beat with a halo pixel on each side
  typedef logic [(LANES+2)*PIX_W-1:0] win_row_t;

  typedef logic [$clog2(BEATS_PER_ROW)-1:0] beat_idx_t;

  // one extra code for the zero flush row below the image
  typedef logic [$clog2(IMG_H+1)-1:0] row_idx_t;

  localparam beat_idx_t LAST_BEAT = beat_idx_t'(BEATS_PER_ROW - 1);
  localparam row_idx_t  LAST_ROW  = row_idx_t'(IMG_H - 1);
  localparam row_idx_t  FLUSH_ROW = row_idx_t'(IMG_H);

endpackage

`default_nettype wire

// File: design/kernel_pkg.sv
`default_nettype none

package kernel_pkg;

  // 1-2-1 taps, applied once per direction
  localparam logic [1:0] W_SIDE   = 2'd1;
  localparam logic [1:0] W_CENTRE = 2'd2;

  // weights sum to 16
  localparam int KERNEL_SHIFT = 4;

  // up to 4 * 255
  typedef logic [9:0] hsum_t;

  // up to 16 * 255 plus rounding
  typedef logic [11:0] vsum_t;

  localparam vsum_t KERNEL_ROUND = 12'd8;

  // window to pixel, in advancing cycles
  localparam int LANE_LATENCY = 2;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STREAM,
    ST_ROW_TAIL,
    ST_FLUSH
  } feed_state_t;

endpackage

`default_nettype wire

// File: design/window_feeder.sv
`timescale 1ns/100ps
`default_nettype none

module window_feeder (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       start,
  input  wire                       in_valid,
  input  wire image_pkg::beat_t     in_data,
  input  wire                       advance,
  output logic                      in_ready,
  output image_pkg::win_row_t       win_top,
  output image_pkg::win_row_t       win_mid,
  output image_pkg::win_row_t       win_bot,
  output logic                      win_valid,
  output logic                      win_last
);

  kernel_pkg::feed_state_t state;
  image_pkg::beat_idx_t    beat_cnt;
  // index of the row entering at the bottom of the window
  image_pkg::row_idx_t     row_cnt;

  // two rows above the incoming one, oldest in row_old
  image_pkg::beat_t row_old [image_pkg::BEATS_PER_ROW];
  image_pkg::beat_t row_new [image_pkg::BEATS_PER_ROW];

  // centre column and the rightmost pixels of the column before it
  image_pkg::beat_t  cur_top;
  image_pkg::beat_t  cur_mid;
  image_pkg::beat_t  cur_bot;
  image_pkg::pixel_t prev_top;
  image_pkg::pixel_t prev_mid;
  image_pkg::pixel_t prev_bot;

  image_pkg::beat_t  col_top;
  image_pkg::beat_t  col_mid;
  image_pkg::beat_t  col_bot;
  image_pkg::pixel_t right_top;
  image_pkg::pixel_t right_mid;
  image_pkg::pixel_t right_bot;

  logic accept;
  logic step;
  logic tail_step;
  logic emit_step;
  logic last_beat;

  function automatic image_pkg::pixel_t low_pix(input image_pkg::beat_t b);
    return b[0 +: image_pkg::PIX_W];
  endfunction

  function automatic image_pkg::pixel_t high_pix(input image_pkg::beat_t b);
    return b[(image_pkg::LANES-1)*image_pkg::PIX_W +: image_pkg::PIX_W];
  endfunction

  function automatic image_pkg::win_row_t make_row(input image_pkg::pixel_t left,
                                                   input image_pkg::beat_t  mid,
                                                   input image_pkg::pixel_t right);
    return {right, mid, left};
  endfunction

  assign in_ready  = (state == kernel_pkg::ST_STREAM) && advance;
  assign accept    = in_valid && in_ready;
  // flush row steps like a stream row but needs no input
  assign step      = accept || ((state == kernel_pkg::ST_FLUSH) && advance);
  assign tail_step = (state == kernel_pkg::ST_ROW_TAIL) && advance;
  assign last_beat = (beat_cnt == image_pkg::LAST_BEAT);

  // beat 0 only completes the previous column, row 0 has no centre row yet
  assign emit_step = step && (beat_cnt != '0) && (row_cnt != '0);

  // zero fill above the image and below it
  always_comb begin
    col_top = (row_cnt >= image_pkg::row_idx_t'(2)) ? row_old[beat_cnt] : '0;
    col_mid = (row_cnt != '0) ? row_new[beat_cnt] : '0;
    col_bot = (state == kernel_pkg::ST_FLUSH) ? '0 : in_data;
  end

  // right edge of the image during the tail cycle
  always_comb begin
    if (state == kernel_pkg::ST_ROW_TAIL) begin
      right_top = '0;
      right_mid = '0;
      right_bot = '0;
    end else begin
      right_top = low_pix(col_top);
      right_mid = low_pix(col_mid);
      right_bot = low_pix(col_bot);
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      row_old[beat_cnt] <= row_new[beat_cnt];
      row_new[beat_cnt] <= col_bot;
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      // left edge of the image reads as zero
      prev_top <= (beat_cnt == '0) ? '0 : high_pix(cur_top);
      prev_mid <= (beat_cnt == '0) ? '0 : high_pix(cur_mid);
      prev_bot <= (beat_cnt == '0) ? '0 : high_pix(cur_bot);
      cur_top  <= col_top;
      cur_mid  <= col_mid;
      cur_bot  <= col_bot;
    end
  end

  always_ff @(posedge clk) begin
    if (emit_step || tail_step) begin
      win_top <= make_row(prev_top, cur_top, right_top);
      win_mid <= make_row(prev_mid, cur_mid, right_mid);
      win_bot <= make_row(prev_bot, cur_bot, right_bot);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid <= 1'b0;
      win_last  <= 1'b0;
    end else if (advance) begin
      win_valid <= emit_step || tail_step;
      win_last  <= tail_step && (row_cnt == image_pkg::FLUSH_ROW);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= kernel_pkg::ST_IDLE;
      beat_cnt <= '0;
      row_cnt  <= '0;
    end else begin
      case (state)
        kernel_pkg::ST_IDLE: begin
          if (start) begin
            state    <= kernel_pkg::ST_STREAM;
            beat_cnt <= '0;
            row_cnt  <= '0;
          end
        end
        kernel_pkg::ST_STREAM, kernel_pkg::ST_FLUSH: begin
          if (step) begin
            if (last_beat) begin
              beat_cnt <= '0;
              if (row_cnt == '0) begin
                // first row only fills the buffers
                row_cnt <= row_cnt + image_pkg::row_idx_t'(1);
                state   <= (row_cnt == image_pkg::LAST_ROW) ?
                           kernel_pkg::ST_FLUSH : kernel_pkg::ST_STREAM;
              end else begin
                state <= kernel_pkg::ST_ROW_TAIL;
              end
            end else begin
              beat_cnt <= beat_cnt + image_pkg::beat_idx_t'(1);
            end
          end
        end
        kernel_pkg::ST_ROW_TAIL: begin
          if (advance) begin
            if (row_cnt == image_pkg::FLUSH_ROW) begin
              state <= kernel_pkg::ST_IDLE;
            end else begin
              row_cnt <= row_cnt + image_pkg::row_idx_t'(1);
              state   <= (row_cnt == image_pkg::LAST_ROW) ?
                         kernel_pkg::ST_FLUSH : kernel_pkg::ST_STREAM;
            end
          end
        end
        default: state <= kernel_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/blur_lane.sv
`timescale 1ns/100ps
`default_nettype none

module blur_lane (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           advance,
  input  wire [3*image_pkg::PIX_W-1:0]  pix_top,
  input  wire [3*image_pkg::PIX_W-1:0]  pix_mid,
  input  wire [3*image_pkg::PIX_W-1:0]  pix_bot,
  output image_pkg::pixel_t             blur_pix
);

  kernel_pkg::hsum_t h_top;
  kernel_pkg::hsum_t h_mid;
  kernel_pkg::hsum_t h_bot;
  kernel_pkg::vsum_t vsum;

  // horizontal 1-2-1 over one row of the window
  function automatic kernel_pkg::hsum_t tap3(input logic [3*image_pkg::PIX_W-1:0] t);
    kernel_pkg::hsum_t a;
    kernel_pkg::hsum_t b;
    kernel_pkg::hsum_t c;
    a = kernel_pkg::hsum_t'(t[0 +: image_pkg::PIX_W]);
    b = kernel_pkg::hsum_t'(t[image_pkg::PIX_W +: image_pkg::PIX_W]);
    c = kernel_pkg::hsum_t'(t[2*image_pkg::PIX_W +: image_pkg::PIX_W]);
    return a * kernel_pkg::hsum_t'(kernel_pkg::W_SIDE)
         + b * kernel_pkg::hsum_t'(kernel_pkg::W_CENTRE)
         + c * kernel_pkg::hsum_t'(kernel_pkg::W_SIDE);
  endfunction

  // stage 1
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_top <= '0;
      h_mid <= '0;
      h_bot <= '0;
    end else if (advance) begin
      h_top <= tap3(pix_top);
      h_mid <= tap3(pix_mid);
      h_bot <= tap3(pix_bot);
    end
  end

  // vertical 1-2-1 plus rounding fits in 12 bits
  always_comb begin
    vsum = kernel_pkg::vsum_t'(h_top) * kernel_pkg::vsum_t'(kernel_pkg::W_SIDE)
         + kernel_pkg::vsum_t'(h_mid) * kernel_pkg::vsum_t'(kernel_pkg::W_CENTRE)
         + kernel_pkg::vsum_t'(h_bot) * kernel_pkg::vsum_t'(kernel_pkg::W_SIDE)
         + kernel_pkg::KERNEL_ROUND;
  end

  // stage 2
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_pix <= '0;
    end else if (advance) begin
      blur_pix <= image_pkg::pixel_t'(vsum >> kernel_pkg::KERNEL_SHIFT);
    end
  end

endmodule

`default_nettype wire

// File: design/strip_packer.sv
`timescale 1ns/100ps
`default_nettype none

module strip_packer (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     start,
  input  wire                     win_valid,
  input  wire                     win_last,
  input  wire image_pkg::beat_t   lane_pix,
  input  wire                     out_ready,
  output logic                    advance,
  output logic                    out_valid,
  output image_pkg::beat_t        out_data,
  output logic                    out_last,
  output logic                    done
);

  localparam int MSB = kernel_pkg::LANE_LATENCY - 1;

  // valid and last travel alongside the lane pipeline
  logic [MSB:0] vld_sr;
  logic [MSB:0] last_sr;
  logic         taken;

  // the whole pipeline stalls only while a held beat waits
  assign advance = !out_valid || out_ready;
  assign taken   = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_sr  <= '0;
      last_sr <= '0;
    end else if (advance) begin
      vld_sr  <= {vld_sr[MSB-1:0], win_valid};
      last_sr <= {last_sr[MSB-1:0], win_last};
    end
  end

  // output beat register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else if (advance) begin
      out_valid <= vld_sr[MSB];
      out_last  <= vld_sr[MSB] && last_sr[MSB];
    end
  end

  always_ff @(posedge clk) begin
    if (advance && vld_sr[MSB]) begin
      out_data <= lane_pix;
    end
  end

  // held from the last beat until the next frame starts
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (start) begin
      done <= 1'b0;
    end else if (taken && out_last) begin
      done <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/gaussian_blur_top.sv
`timescale 1ns/100ps
`default_nettype none

module gaussian_blur_top (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     start,
  input  wire                     in_valid,
  input  wire image_pkg::beat_t   in_data,
  input  wire                     out_ready,
  output logic                    in_ready,
  output logic                    out_valid,
  output image_pkg::beat_t        out_data,
  output logic                    out_last,
  output logic                    done
);

  image_pkg::win_row_t win_top;
  image_pkg::win_row_t win_mid;
  image_pkg::win_row_t win_bot;
  logic                win_valid;
  logic                win_last;
  logic                advance;
  image_pkg::beat_t    lane_pix;

  window_feeder u_feeder (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .advance   (advance),
    .in_ready  (in_ready),
    .win_top   (win_top),
    .win_mid   (win_mid),
    .win_bot   (win_bot),
    .win_valid (win_valid),
    .win_last  (win_last)
  );

  // lane i sees window pixels i to i+2 of each row
  for (genvar i = 0; i < image_pkg::LANES; i++) begin : g_lane
    blur_lane u_lane (
      .clk      (clk),
      .rst_n    (rst_n),
      .advance  (advance),
      .pix_top  (win_top[i*image_pkg::PIX_W +: 3*image_pkg::PIX_W]),
      .pix_mid  (win_mid[i*image_pkg::PIX_W +: 3*image_pkg::PIX_W]),
      .pix_bot  (win_bot[i*image_pkg::PIX_W +: 3*image_pkg::PIX_W]),
      .blur_pix (lane_pix[i*image_pkg::PIX_W +: image_pkg::PIX_W])
    );
  end

  strip_packer u_packer (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .win_valid (win_valid),
    .win_last  (win_last),
    .lane_pix  (lane_pix),
    .out_ready (out_ready),
    .advance   (advance),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_last  (out_last),
    .done      (done)
  );

endmodule

`default_nettype wire

// File: test/clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: test/tb_gaussian_blur.sv
`timescale 1ns/100ps
`default_nettype none

module tb_gaussian_blur;

  localparam int TOTAL_BEATS     = image_pkg::IMG_H * image_pkg::BEATS_PER_ROW;
  localparam int NUM_IMAGES      = 3;
  localparam int WATCHDOG_CYCLES = NUM_IMAGES * 200 * TOTAL_BEATS;
  localparam logic [31:0] SEED   = 32'h0475502b;

  logic             clk;
  logic             rst_n;
  logic             start;
  logic             in_valid;
  image_pkg::beat_t in_data;
  logic             out_ready;
  logic             in_ready;
  logic             out_valid;
  image_pkg::beat_t out_data;
  logic             out_last;
  logic             done;

  image_pkg::pixel_t img [image_pkg::IMG_H][image_pkg::IMG_W];

  int errors;
  int checks;

  clock_gen u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  gaussian_blur_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_last  (out_last),
    .done      (done)
  );

  // zero outside the frame
  function automatic int pix_at(input int y, input int x);
    if (x < 0 || x >= image_pkg::IMG_W || y < 0 || y >= image_pkg::IMG_H) begin
      return 0;
    end
    return int'(img[y][x]);
  endfunction

  function automatic int tap_weight(input int d);
    return (d == 0) ? 2 : 1;
  endfunction

  // 1-2-1 by 1-2-1 with weights summing to 16 and rounding half up
  function automatic image_pkg::pixel_t blur_model(input int y, input int x);
    int sum;
    sum = 0;
    for (int dy = -1; dy <= 1; dy++) begin
      for (int dx = -1; dx <= 1; dx++) begin
        sum += tap_weight(dy) * tap_weight(dx) * pix_at(y + dy, x + dx);
      end
    end
    return image_pkg::pixel_t'((sum + 8) >> 4);
  endfunction

  // k is the raster beat number
  function automatic image_pkg::beat_t input_beat(input int k);
    image_pkg::beat_t b;
    int y;
    int x0;
    y  = k / image_pkg::BEATS_PER_ROW;
    x0 = (k % image_pkg::BEATS_PER_ROW) * image_pkg::LANES;
    for (int i = 0; i < image_pkg::LANES; i++) begin
      b[i*image_pkg::PIX_W +: image_pkg::PIX_W] = img[y][x0 + i];
    end
    return b;
  endfunction

  function automatic image_pkg::beat_t expected_beat(input int k);
    image_pkg::beat_t b;
    int y;
    int x0;
    y  = k / image_pkg::BEATS_PER_ROW;
    x0 = (k % image_pkg::BEATS_PER_ROW) * image_pkg::LANES;
    for (int i = 0; i < image_pkg::LANES; i++) begin
      b[i*image_pkg::PIX_W +: image_pkg::PIX_W] = blur_model(y, x0 + i);
    end
    return b;
  endfunction

  // third frame gets many saturated pixels to hit the widest sums
  task automatic fill_image(input int n);
    for (int y = 0; y < image_pkg::IMG_H; y++) begin
      for (int x = 0; x < image_pkg::IMG_W; x++) begin
        if (n == 2 && ($urandom % 2) == 0) begin
          img[y][x] = 8'hff;
        end else begin
          img[y][x] = 8'($urandom);
        end
      end
    end
  endtask

  task automatic check_idle_outputs();
    @(negedge clk);
    #2;
    if (in_ready !== 1'b0) begin
      $display("mismatch in_ready: expected 0 got %h", in_ready);
      errors++;
    end
    if (out_valid !== 1'b0) begin
      $display("mismatch out_valid: expected 0 got %h", out_valid);
      errors++;
    end
    if (out_last !== 1'b0) begin
      $display("mismatch out_last: expected 0 got %h", out_last);
      errors++;
    end
    if (done !== 1'b0) begin
      $display("mismatch done: expected 0 got %h", done);
      errors++;
    end
  endtask

  task automatic pulse_start();
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    #2;
    if (done !== 1'b0) begin
      $display("mismatch done after start: expected 0 got %h", done);
      errors++;
    end
  endtask

  // inputs change on the falling edge and outputs are sampled 2 ns later
  task automatic stream_image();
    int in_idx;
    int out_idx;
    logic accepted;
    logic held;
    logic exp_last;
    image_pkg::beat_t held_data;
    image_pkg::beat_t exp;
    in_idx   = 0;
    out_idx  = 0;
    accepted = 1'b0;
    held     = 1'b0;
    held_data = '0;
    while (out_idx < TOTAL_BEATS) begin
      @(negedge clk);
      if (accepted) begin
        in_valid = 1'b0;
      end
      if (!in_valid && in_idx < TOTAL_BEATS && ($urandom % 4) != 0) begin
        in_valid = 1'b1;
        in_data  = input_beat(in_idx);
      end
      out_ready = (($urandom % 3) != 0);
      #2;
      accepted = in_valid && in_ready;
      if (accepted) begin
        in_idx++;
      end
      if (done !== 1'b0) begin
        $display("mismatch done during frame: expected 0 got %h", done);
        errors++;
      end
      // a stalled beat must not change
      if (held && (out_valid !== 1'b1 || out_data !== held_data)) begin
        $display("mismatch out_data held: expected %h got %h", held_data, out_data);
        errors++;
      end
      held = 1'b0;
      if (out_valid === 1'b1) begin
        if (out_ready) begin
          exp      = expected_beat(out_idx);
          exp_last = (out_idx == TOTAL_BEATS - 1);
          checks++;
          if (out_data !== exp) begin
            $display("mismatch out_data beat %0d: expected %h got %h", out_idx, exp, out_data);
            errors++;
          end
          if (out_last !== exp_last) begin
            $display("mismatch out_last beat %0d: expected %h got %h",
                     out_idx, exp_last, out_last);
            errors++;
          end
          out_idx++;
        end else begin
          held      = 1'b1;
          held_data = out_data;
        end
      end
    end
  endtask

  task automatic check_done_hold(input int idle_cycles);
    @(negedge clk);
    in_valid  = 1'b0;
    out_ready = 1'b0;
    #2;
    if (done !== 1'b1) begin
      $display("mismatch done after last beat: expected 1 got %h", done);
      errors++;
    end
    for (int c = 0; c < idle_cycles; c++) begin
      @(negedge clk);
      out_ready = (($urandom % 2) != 0);
      #2;
      if (done !== 1'b1) begin
        $display("mismatch done while idle: expected 1 got %h", done);
        errors++;
      end
      if (out_valid !== 1'b0) begin
        $display("mismatch out_valid after last beat: expected 0 got %h", out_valid);
        errors++;
      end
    end
  endtask

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    void'($urandom(SEED));
    errors    = 0;
    checks    = 0;
    start     = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    @(posedge rst_n);
    repeat (3) check_idle_outputs();
    for (int n = 0; n < NUM_IMAGES; n++) begin
      fill_image(n);
      pulse_start();
      stream_image();
      check_done_hold(4 + int'($urandom % 8));
    end
    $display("beats checked %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
design/image_pkg.sv
design/kernel_pkg.sv
design/window_feeder.sv
design/blur_lane.sv
design/strip_packer.sv
design/gaussian_blur_top.sv
test/clock_gen.sv
test/tb_gaussian_blur.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
TOP       := tb_gaussian_blur
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
